// File: vlog.f
+incdir+design
design/dcache_pkg.sv
design/sdp_ram.sv
design/dcache_data_array.sv
design/dcache_tag_array.sv
design/dcache.sv
verification/tb_clock_gen.sv
verification/tb_checker.sv
verification/tb_dcache.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_dcache
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) && echo "sim: pass" || (echo "sim: fail" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam int    wait_limit  = 200;
    localparam int    num_entries = 15;
    localparam word_t fill_key    = 32'h5a5a_0f0f;   // memory pattern, addr ^ key

    typedef struct packed {
        logic  op;
        addr_t addr;
        strb_t wstrb;
        word_t wdata;
        logic  miss;
        logic  wb;
        addr_t wb_addr;
    } entry_t;

    // set 3 sees tags 1, 2 and 3; set 8 a single cold store
    entry_t ops [num_entries] = '{
        '{1'b0, 32'h0000_1064, 4'b0000, 32'h0000_0000, 1'b1, 1'b0, 32'h0},
        '{1'b0, 32'h0000_1078, 4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0},
        '{1'b1, 32'h0000_1068, 4'b0011, 32'hdead_beef, 1'b0, 1'b0, 32'h0},
        '{1'b0, 32'h0000_1068, 4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0},
        '{1'b1, 32'h0000_2070, 4'b1100, 32'h1234_5678, 1'b1, 1'b0, 32'h0},
        '{1'b0, 32'h0000_2070, 4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0},
        '{1'b0, 32'h0000_3064, 4'b0000, 32'h0000_0000, 1'b1, 1'b1, 32'h0000_1060},
        '{1'b0, 32'h0000_2064, 4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0},
        '{1'b0, 32'h0000_1068, 4'b0000, 32'h0000_0000, 1'b1, 1'b0, 32'h0},  // clean victim
        '{1'b1, 32'h0000_1070, 4'b1111, 32'hcafe_f00d, 1'b0, 1'b0, 32'h0},
        '{1'b0, 32'h0000_1070, 4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0},
        '{1'b1, 32'h0000_5104, 4'b0101, 32'ha5a5_5a5a, 1'b1, 1'b0, 32'h0},
        '{1'b0, 32'h0000_5104, 4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0},
        '{1'b0, 32'h0000_2060, 4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0},
        '{1'b0, 32'h0000_3060, 4'b0000, 32'h0000_0000, 1'b1, 1'b1, 32'h0000_1060}
    };

    logic  clk;
    logic  reset;
    logic  valid;
    logic  op;
    addr_t virtual_addr;
    strb_t wstrb;
    word_t wdata;
    logic  stall;
    logic  data_ok;
    word_t rdata;
    logic  rd_req;
    addr_t rd_addr;
    logic  rd_rdy;
    logic  ret_valid;
    line_t ret_data;
    logic  wr_req;
    addr_t wr_addr;
    line_t wr_data;
    logic  wr_rdy;
    logic  exp_miss;
    logic  exp_wb;
    addr_t exp_wb_addr;
    int    done_count;
    int    error_count;
    logic  timed_out;

    line_t mem_lines [addr_t];   // keyed by line address

    function automatic line_t fetch_line(addr_t a);
        line_t l;
        if (mem_lines.exists(a)) begin
            return mem_lines[a];
        end
        for (int b = 0; b < `BANK_NUM; b++) begin
            l[b*`DATA_SIZE +: `DATA_SIZE] = (a + addr_t'(4 * b)) ^ fill_key;
        end
        return l;
    endfunction

    tb_clock_gen #(.period_ns(8.0)) clock_i (.clk(clk));

    dcache dut_i (
        .clk(clk), .reset(reset),
        .valid(valid), .op(op), .virtual_addr(virtual_addr), .wstrb(wstrb), .wdata(wdata),
        .stall(stall), .data_ok(data_ok), .rdata(rdata),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_data(ret_data),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_rdy(wr_rdy)
    );

    tb_checker checker_i (
        .clk(clk), .reset(reset),
        .valid(valid), .op(op), .addr(virtual_addr), .wstrb(wstrb), .wdata(wdata),
        .stall(stall), .data_ok(data_ok), .rdata(rdata),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
        .exp_miss(exp_miss), .exp_wb(exp_wb), .exp_wb_addr(exp_wb_addr),
        .done_count(done_count), .error_count(error_count)
    );

    // memory model, refill returns 0 to 3 cycles after the rd_rdy handshake
    initial begin
        logic  refill_busy;
        int    ret_delay;
        addr_t refill_addr;
        refill_busy = 1'b0;
        ret_delay   = 0;
        refill_addr = '0;
        rd_rdy      = 1'b0;
        wr_rdy      = 1'b0;
        ret_valid   = 1'b0;
        ret_data    = '0;
        void'($urandom(32'hebee_54e8));
        forever begin
            @(posedge clk);
            ret_valid <= 1'b0;
            if (wr_req) begin
                mem_lines[wr_addr] = wr_data;
            end
            if (refill_busy) begin
                if (ret_delay == 0) begin
                    ret_valid   <= 1'b1;
                    ret_data    <= fetch_line(refill_addr);
                    refill_busy = 1'b0;
                end else begin
                    ret_delay--;
                end
            end else if (rd_req && rd_rdy) begin
                refill_busy = 1'b1;
                refill_addr = rd_addr;
                ret_delay   = $urandom_range(3, 0);
            end
            rd_rdy <= ($urandom_range(2, 0) == 0);
            wr_rdy <= ($urandom_range(1, 0) == 0);
        end
    end

    initial begin
        int n;
        reset        = 1'b1;
        valid        = 1'b0;
        op           = 1'b0;
        virtual_addr = '0;
        wstrb        = '0;
        wdata        = '0;
        exp_miss     = 1'b0;
        exp_wb       = 1'b0;
        exp_wb_addr  = '0;
        timed_out    = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        // next entry goes out on the edge that takes the previous one
        for (int i = 0; i < num_entries && !timed_out; i++) begin
            valid        <= 1'b1;
            op           <= ops[i].op;
            virtual_addr <= ops[i].addr;
            wstrb        <= ops[i].wstrb;
            wdata        <= ops[i].wdata;
            exp_miss     <= ops[i].miss;
            exp_wb       <= ops[i].wb;
            exp_wb_addr  <= ops[i].wb_addr;
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (stall && n < wait_limit);
            if (stall) begin
                timed_out = 1'b1;
                $display("timeout: entry %0d was never accepted", i);
            end else begin
                @(posedge clk);
            end
        end
        valid <= 1'b0;
        n = 0;
        while (!timed_out && done_count < num_entries) begin
            @(negedge clk);
            n++;
            if (n == wait_limit) begin
                timed_out = 1'b1;
                $display("timeout: only %0d of %0d entries completed", done_count, num_entries);
            end
        end
        $display("%0d of %0d entries completed, %0d errors", done_count, num_entries,
                 error_count);
        if (timed_out || error_count != 0) begin
            $display("TESTS FAILED");
        end else begin
            $display("TESTS PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module tb_checker (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid,
    input  logic              op,
    input  dcache_pkg::addr_t addr,
    input  dcache_pkg::strb_t wstrb,
    input  dcache_pkg::word_t wdata,
    input  logic              stall,
    input  logic              data_ok,
    input  dcache_pkg::word_t rdata,
    input  logic              rd_req,
    input  dcache_pkg::addr_t rd_addr,
    input  logic              rd_rdy,
    input  logic              wr_req,
    input  dcache_pkg::addr_t wr_addr,
    input  dcache_pkg::line_t wr_data,
    input  logic              exp_miss,
    input  logic              exp_wb,
    input  dcache_pkg::addr_t exp_wb_addr,
    output int                done_count,
    output int                error_count
);
    import dcache_pkg::*;

    localparam word_t fill_key = 32'h5a5a_0f0f;   // untouched words read as addr ^ key

    typedef struct packed {
        logic [31:0] id;
        logic        op;
        addr_t       addr;
        strb_t       wstrb;
        word_t       wdata;
        logic        miss;
        logic        wb;
        addr_t       wb_addr;
    } pending_t;

    pending_t pending [$];   // oldest request at the front
    word_t    shadow [addr_t];
    int       accepted;
    int       refills_seen;
    int       writebacks_seen;

    function automatic word_t shadow_word(addr_t a);
        addr_t wa;
        wa = {a[`ADDR_SIZE-1:2], 2'b00};
        if (shadow.exists(wa)) begin
            return shadow[wa];
        end
        return wa ^ fill_key;
    endfunction

    function automatic line_t shadow_line(addr_t a);
        line_t l;
        for (int b = 0; b < `BANK_NUM; b++) begin
            l[b*`DATA_SIZE +: `DATA_SIZE] =
                shadow_word({a[`ADDR_SIZE-1:`OFFSET_SIZE], 5'b0} + addr_t'(4 * b));
        end
        return l;
    endfunction

    task automatic complete_front();
        pending_t p;
        word_t    expect_word;
        int       errors_before;
        p             = pending.pop_front();
        errors_before = error_count;
        expect_word   = shadow_word(p.addr);
        if (p.op) begin
            for (int i = 0; i < `DATA_SIZE/8; i++) begin
                if (p.wstrb[i]) begin
                    expect_word[i*8 +: 8] = p.wdata[i*8 +: 8];
                end
            end
            shadow[{p.addr[`ADDR_SIZE-1:2], 2'b00}] = expect_word;
        end else if (rdata !== expect_word) begin
            $display("[FAIL] %0t rdata: got %h, expected %h", $time, rdata, expect_word);
            error_count++;
        end
        if (refills_seen != int'(p.miss)) begin
            $display("entry %0d expected %0d refill(s) but saw %0d", p.id, p.miss, refills_seen);
            error_count++;
        end
        if (writebacks_seen != int'(p.wb)) begin
            $display("entry %0d expected %0d writeback(s) but saw %0d",
                     p.id, p.wb, writebacks_seen);
            error_count++;
        end
        refills_seen    = 0;
        writebacks_seen = 0;
        done_count++;
        $display("entry %0d %s 0x%h %s", p.id, p.op ? "store" : "load", p.addr,
                 (error_count == errors_before) ? "ok" : "failed");
    endtask

    task automatic check_writeback();
        line_t expect_line;
        if (pending.size() == 0) begin
            $display("wr_req at %0t with no request outstanding", $time);
            error_count++;
        end else begin
            writebacks_seen++;
            if (pending[0].wb && wr_addr !== pending[0].wb_addr) begin
                $display("[FAIL] %0t wr_addr: got %h, expected %h",
                         $time, wr_addr, pending[0].wb_addr);
                error_count++;
            end
            expect_line = shadow_line(wr_addr);
            if (wr_data !== expect_line) begin
                $display("[FAIL] %0t wr_data: got %h, expected %h",
                         $time, wr_data, expect_line);
                error_count++;
            end
        end
    endtask

    // completions first, then new requests, as the dcache retires in order
    always @(posedge clk) begin
        if (reset) begin
            done_count      = 0;
            error_count     = 0;
            accepted        = 0;
            refills_seen    = 0;
            writebacks_seen = 0;
        end else begin
            if (data_ok) begin
                if (pending.size() == 0) begin
                    $display("data_ok at %0t with no request outstanding", $time);
                    error_count++;
                end else begin
                    complete_front();
                end
            end
            if (wr_req) begin
                check_writeback();
            end
            if (rd_req && rd_rdy && pending.size() != 0) begin
                refills_seen++;
                if (rd_addr !== {pending[0].addr[`ADDR_SIZE-1:`OFFSET_SIZE], 5'b0}) begin
                    $display("[FAIL] %0t rd_addr: got %h, expected %h", $time, rd_addr,
                             {pending[0].addr[`ADDR_SIZE-1:`OFFSET_SIZE], 5'b0});
                    error_count++;
                end
            end
            if (valid && !stall) begin
                pending.push_back('{id: accepted, op: op, addr: addr, wstrb: wstrb,
                                    wdata: wdata, miss: exp_miss, wb: exp_wb,
                                    wb_addr: exp_wb_addr});
                accepted++;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real period_ns = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: design/dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache (
    input  logic              clk,
    input  logic              reset,

    input  logic              valid,
    input  logic              op,            // set for a store
    input  dcache_pkg::addr_t virtual_addr,
    input  dcache_pkg::strb_t wstrb,
    input  dcache_pkg::word_t wdata,

    output logic              stall,
    output logic              data_ok,
    output dcache_pkg::word_t rdata,

    output logic              rd_req,
    output dcache_pkg::addr_t rd_addr,
    input  logic              rd_rdy,
    input  logic              ret_valid,
    input  dcache_pkg::line_t ret_data,

    output logic              wr_req,
    output dcache_pkg::addr_t wr_addr,
    output dcache_pkg::line_t wr_data,
    input  logic              wr_rdy
);
    import dcache_pkg::*;

    req_t          req_q;
    logic          req_valid_q;
    logic          conflict_q;     // store hit wrote the set just read
    dcache_state_t state;
    dcache_state_t state_next;

    addr_t  physical_addr;
    index_t in_index;
    index_t req_index;
    index_t rd_index;
    tag_t   req_tag;
    bank_t  req_bank;

    logic   lookup_valid;
    logic   hit;
    logic   hit_way;
    logic   miss;
    logic   load_hit;
    logic   store_hit;
    logic   refill_en;
    logic   victim_way;
    logic   victim_dirty;
    tag_t   victim_tag;

    line_t  way0_line;
    line_t  way1_line;
    line_t  hit_line;
    line_t  victim_line;
    line_t  wr_line;
    word_t  hit_word;
    word_t  merged_word;
    word_t  byte_mask;
    logic [1:0] way_wr_en;
    logic [`BANK_NUM*`DATA_SIZE/8-1:0] bank_strb;

    assign physical_addr = virtual_addr;   // identity map, no tlb here

    assign in_index  = physical_addr[`OFFSET_SIZE +: `INDEX_SIZE];
    assign req_index = req_q.addr[`OFFSET_SIZE +: `INDEX_SIZE];
    assign req_tag   = req_q.addr[`ADDR_SIZE-1 -: `TAG_SIZE];
    assign req_bank  = req_q.addr[`OFFSET_SIZE-1:2];
    assign rd_index  = stall ? req_index : in_index;   // hold the set while stalled

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid_q <= 1'b0;
            conflict_q  <= 1'b0;
        end else begin
            conflict_q <= store_hit && valid && !stall && (in_index == req_index);
            if (!stall) begin
                req_valid_q <= valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            req_q <= '{op: op, addr: physical_addr, wstrb: wstrb, wdata: wdata};
        end
    end

    assign lookup_valid = req_valid_q && !conflict_q && (state == lookup);
    assign miss         = lookup_valid && !hit;
    assign load_hit     = hit && !req_q.op;
    assign store_hit    = hit && req_q.op;
    assign refill_en    = (state == refill_wait) && ret_valid;

    assign stall   = reset || conflict_q || miss || (state != lookup);
    assign data_ok = hit;

    assign hit_line    = hit_way ? way1_line : way0_line;
    assign victim_line = victim_way ? way1_line : way0_line;
    assign hit_word    = hit_line[req_bank*`DATA_SIZE +: `DATA_SIZE];
    assign rdata       = hit_word;

    always_comb begin
        for (int i = 0; i < `DATA_SIZE/8; i++) begin
            byte_mask[i*8 +: 8] = {8{req_q.wstrb[i]}};
        end
    end

    assign merged_word = (req_q.wdata & byte_mask) | (hit_word & ~byte_mask);

    // refill writes the whole line, a store hit only its bank
    always_comb begin
        way_wr_en = 2'b00;
        bank_strb = '0;
        wr_line   = {`BANK_NUM{merged_word}};
        if (refill_en) begin
            way_wr_en[victim_way] = 1'b1;
            bank_strb             = '1;
            wr_line               = ret_data;
        end else if (store_hit) begin
            way_wr_en[hit_way] = 1'b1;
            bank_strb[req_bank*(`DATA_SIZE/8) +: `DATA_SIZE/8] = '1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            lookup: begin
                if (miss) begin
                    state_next = victim_dirty ? writeback : refill_req;
                end
            end
            writeback: begin
                if (wr_rdy) begin
                    state_next = refill_req;
                end
            end
            refill_req: begin
                if (rd_rdy) begin
                    state_next = refill_wait;
                end
            end
            refill_wait: begin
                if (ret_valid) begin
                    state_next = replay;
                end
            end
            replay:  state_next = lookup;   // re-read the refilled set
            default: state_next = lookup;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= lookup;
            wr_req <= 1'b0;
        end else begin
            state  <= state_next;
            wr_req <= (state == writeback) && wr_rdy;
        end
    end

    // victim line stays on the ram outputs while stalled
    always_ff @(posedge clk) begin
        if ((state == writeback) && wr_rdy) begin
            wr_addr <= {victim_tag, req_index, {`OFFSET_SIZE{1'b0}}};
            wr_data <= victim_line;
        end
    end

    assign rd_req  = (state == refill_req);
    assign rd_addr = {req_q.addr[`ADDR_SIZE-1:`OFFSET_SIZE], {`OFFSET_SIZE{1'b0}}};

    dcache_data_array data_array_i (
        .clk      (clk),
        .rd_index (rd_index),
        .wr_index (req_index),
        .way_wr_en(way_wr_en),
        .bank_strb(bank_strb),
        .wr_line  (wr_line),
        .way0_line(way0_line),
        .way1_line(way1_line)
    );

    dcache_tag_array tag_array_i (
        .clk         (clk),
        .reset       (reset),
        .rd_index    (rd_index),
        .lookup_index(req_index),
        .lookup_tag  (req_tag),
        .lookup_valid(lookup_valid),
        .refill_en   (refill_en),
        .refill_way  (victim_way),
        .store_hit_en(store_hit),
        .load_hit_en (load_hit),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .victim_dirty(victim_dirty),
        .victim_tag  (victim_tag)
    );

    rd_req_held: assert property (@(posedge clk) disable iff (reset)
        rd_req && !rd_rdy |=> rd_req)
        else $error("dcache: rd_req dropped before rd_rdy");

    wr_req_pulse: assert property (@(posedge clk) disable iff (reset)
        wr_req |=> !wr_req)
        else $error("dcache: wr_req longer than one cycle");

    // refilled line must hit once the replay has re-read the set
    replay_hits: assert property (@(posedge clk) disable iff (reset)
        refill_en |=> ##1 data_ok)
        else $error("dcache: replay after refill did not hit");

endmodule

`default_nettype wire

// File: design/dcache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_tag_array (
    input  logic               clk,
    input  logic               reset,
    input  dcache_pkg::index_t rd_index,
    input  dcache_pkg::index_t lookup_index,
    input  dcache_pkg::tag_t   lookup_tag,
    input  logic               lookup_valid,
    input  logic               refill_en,
    input  logic               refill_way,
    input  logic               store_hit_en,
    input  logic               load_hit_en,
    output logic               hit,
    output logic               hit_way,
    output logic               victim_way,
    output logic               victim_dirty,
    output dcache_pkg::tag_t   victim_tag
);
    import dcache_pkg::*;

    tagv_t                    rd_tagv [2];
    tagv_t                    refill_tagv;
    logic [1:0]               way_match;
    logic [1:0]               valid_q;      // lines up with the ram read
    logic [1:0][`SET_NUM-1:0] valid_bits;
    logic [1:0][`SET_NUM-1:0] dirty_bits;
    logic [`SET_NUM-1:0]      lru_bits;     // names the next victim

    assign refill_tagv = '{valid: 1'b1, tag: lookup_tag};

    for (genvar w = 0; w < 2; w++) begin : g_way
        sdp_ram #(
            .data_width($bits(tagv_t)),
            .depth     (`SET_NUM)
        ) tagv_ram (
            .clk    (clk),
            .wr_en  (refill_en && (refill_way == 1'(w))),
            .wr_strb('1),
            .wr_addr(lookup_index),
            .wr_data(refill_tagv),
            .rd_addr(rd_index),
            .rd_data(rd_tagv[w])
        );

        assign way_match[w] = rd_tagv[w].valid && valid_q[w] &&
                              (rd_tagv[w].tag == lookup_tag);
    end

    assign hit          = lookup_valid && (|way_match);
    assign hit_way      = way_match[1];
    assign victim_way   = lru_bits[lookup_index];
    assign victim_dirty = dirty_bits[victim_way][lookup_index];
    assign victim_tag   = rd_tagv[victim_way].tag;

    // the tag ram itself has no reset, these flags clear the sets
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            valid_q    <= '0;
        end else begin
            if (refill_en) begin
                valid_bits[refill_way][lookup_index] <= 1'b1;
            end
            valid_q <= {valid_bits[1][rd_index], valid_bits[0][rd_index]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_bits   <= '0;
            dirty_bits <= '0;
        end else if (refill_en) begin
            lru_bits[lookup_index]               <= ~refill_way;   // filled way now recent
            dirty_bits[refill_way][lookup_index] <= 1'b0;
        end else if (store_hit_en || load_hit_en) begin
            lru_bits[lookup_index] <= ~hit_way;
            if (store_hit_en) begin
                dirty_bits[hit_way][lookup_index] <= 1'b1;
            end
        end
    end

    // refill only ever fills the lru way, so a tag lives in one way
    one_way_hit: assert property (@(posedge clk) disable iff (reset)
        lookup_valid |-> !(&way_match))
        else $error("dcache_tag_array: tag present in both ways");

endmodule

`default_nettype wire

// File: design/dcache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_data_array (
    input  logic                              clk,
    input  dcache_pkg::index_t                rd_index,
    input  dcache_pkg::index_t                wr_index,
    input  logic [1:0]                        way_wr_en,
    input  logic [`BANK_NUM*`DATA_SIZE/8-1:0] bank_strb,   // four per bank
    input  dcache_pkg::line_t                 wr_line,
    output dcache_pkg::line_t                 way0_line,
    output dcache_pkg::line_t                 way1_line
);
    import dcache_pkg::*;

    localparam int bytes_per_word = `DATA_SIZE / 8;

    line_t rd_line [2];

    // one ram per word so a store touches a single bank
    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar b = 0; b < `BANK_NUM; b++) begin : g_bank
            sdp_ram #(
                .data_width(`DATA_SIZE),
                .depth     (`SET_NUM)
            ) bank_ram (
                .clk    (clk),
                .wr_en  (way_wr_en[w] && (|bank_strb[b*bytes_per_word +: bytes_per_word])),
                .wr_strb(bank_strb[b*bytes_per_word +: bytes_per_word]),
                .wr_addr(wr_index),
                .wr_data(wr_line[b*`DATA_SIZE +: `DATA_SIZE]),
                .rd_addr(rd_index),
                .rd_data(rd_line[w][b*`DATA_SIZE +: `DATA_SIZE])
            );
        end
    end

    assign way0_line = rd_line[0];
    assign way1_line = rd_line[1];

endmodule

`default_nettype wire

// File: design/sdp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sdp_ram #(
    parameter int data_width = 32,
    parameter int depth      = 128
) (
    input  logic                        clk,
    input  logic                        wr_en,
    input  logic [(data_width+7)/8-1:0] wr_strb,
    input  logic [$clog2(depth)-1:0]    wr_addr,
    input  logic [data_width-1:0]       wr_data,
    input  logic [$clog2(depth)-1:0]    rd_addr,
    output logic [data_width-1:0]       rd_data
);

    logic [data_width-1:0] mem [depth];
    logic [data_width-1:0] bit_mask;

    // top byte may be partial
    always_comb begin
        for (int i = 0; i < data_width; i++) begin
            bit_mask[i] = wr_strb[i/8];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= (wr_data & bit_mask) | (mem[wr_addr] & ~bit_mask);
        end
        rd_data <= mem[rd_addr];   // old contents on a same-address write
    end

    wr_addr_known: assert property (@(posedge clk) wr_en |-> !$isunknown(wr_addr))
        else $error("sdp_ram: unknown write address");

endmodule

`default_nettype wire

// File: design/dcache_pkg.sv
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [`ADDR_SIZE-1:0]           addr_t;
    typedef logic [`DATA_SIZE-1:0]           word_t;
    typedef logic [`BANK_NUM*`DATA_SIZE-1:0] line_t;   // bank 0 in low bits
    typedef logic [`TAG_SIZE-1:0]            tag_t;
    typedef logic [`INDEX_SIZE-1:0]          index_t;
    typedef logic [`OFFSET_SIZE-3:0]         bank_t;   // word within the line
    typedef logic [`DATA_SIZE/8-1:0]         strb_t;

    // one accepted core request
    typedef struct packed {
        logic  op;      // set for a store
        addr_t addr;
        strb_t wstrb;
        word_t wdata;
    } req_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    typedef enum logic [2:0] {
        lookup,
        writeback,
        refill_req,
        refill_wait,
        replay
    } dcache_state_t;

endpackage

`default_nettype wire

// File: design/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// address and data widths
`define ADDR_SIZE   32
`define DATA_SIZE   32

// address split into tag, set index and byte offset
`define TAG_SIZE    20
`define INDEX_SIZE  7
`define OFFSET_SIZE 5

// words per line
`define BANK_NUM    8

// sets per way
`define SET_NUM     128

`endif
